//--- include/tcb_defines.svh
`ifndef TCB_DEFINES_SVH
`define TCB_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Bus geometry
//////////////////////////////////////////////////////////////////////

// Byte address width
`define TCB_ADR_W 10

// Data bus width in bits
`define TCB_DAT_W 32

// Number of byte lanes on the data bus
`define TCB_BEN_W 4

// Read response delay in clock cycles
`define TCB_DLY 1

// SRAM size in words
`define TCB_MEM_DEPTH 256

`endif

//--- src/tcb_pkg.sv
`include "tcb_defines.svh"

package tcb_pkg;

  //////////////////////////////////////////////////////////////////////
  // Plain vector types
  //////////////////////////////////////////////////////////////////////

  // Byte address
  typedef logic [`TCB_ADR_W-1:0] tcb_adr_t;
  // Read or write data
  typedef logic [`TCB_DAT_W-1:0] tcb_dat_t;
  // Byte enables
  typedef logic [`TCB_BEN_W-1:0] tcb_ben_t;
  // Log2 of transfer size in bytes
  typedef logic [1:0] tcb_siz_t;
  // Transfer counter
  typedef logic [15:0] tcb_cnt_t;

  //////////////////////////////////////////////////////////////////////
  // Bus structs
  //////////////////////////////////////////////////////////////////////

  // Log-size request as issued by the manager
  typedef struct packed {
    logic     wen;
    tcb_adr_t adr;
    tcb_siz_t siz;
    tcb_dat_t wdt;
  } tcb_req_t;

  // Byte-enable request toward the word memory
  typedef struct packed {
    logic                  wen;
    logic [`TCB_ADR_W-3:0] adr;
    tcb_ben_t              ben;
    tcb_dat_t              wdt;
  } tcb_breq_t;

  // Response carries read data only
  typedef struct packed {
    tcb_dat_t rdt;
  } tcb_rsp_t;

  // Monitor counters and sticky flags
  typedef struct packed {
    tcb_cnt_t cnt_rd;
    tcb_cnt_t cnt_wr;
    logic     err_hold;
    logic     err_align;
  } tcb_mon_t;

  // Memory write sequencing
  typedef enum logic [0:0] {
    IDLE,
    RMW
  } tcb_mem_state_e;

endpackage

//--- src/tcb_monitor.sv
module tcb_monitor (
  input  logic              tcb,
  input  logic              rst_n,
  input  logic              vld,
  input  tcb_pkg::tcb_req_t req,
  input  logic              rdy,
  output tcb_pkg::tcb_mon_t mon
);

  import tcb_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Local signals
  //////////////////////////////////////////////////////////////////////

  // Bus delayed by one clock
  logic     vld_q;
  logic     rdy_q;
  tcb_req_t req_q;

  // Transfer on this edge
  logic       trn;
  // Previous cycle was a stall
  logic       stall_q;
  logic       hold_err;
  // Address bits that must be zero for the size
  logic [1:0] align_msk;
  logic       align_err;

  //////////////////////////////////////////////////////////////////////
  // Delay the bus
  //////////////////////////////////////////////////////////////////////

  // Handshake state is reset to an idle bus
  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      vld_q <= 1'b0;
      rdy_q <= 1'b1;
    end else begin
      vld_q <= vld;
      rdy_q <= rdy;
    end
  end

  // Request payload only matters behind vld_q
  always_ff @(posedge tcb) begin
    req_q <= req;
  end

  //////////////////////////////////////////////////////////////////////
  // Protocol checks
  //////////////////////////////////////////////////////////////////////

  assign trn     = vld & rdy;
  assign stall_q = vld_q & ~rdy_q;

  // After a stall the manager must keep vld and the request unchanged
  assign hold_err = stall_q & (~vld | (req != req_q));

  // Byte needs no alignment, halfword needs bit 0 clear, word both bits
  always_comb begin
    case (req.siz)
      2'd0:    align_msk = 2'b00;
      2'd1:    align_msk = 2'b01;
      default: align_msk = 2'b11;
    endcase
  end

  // Only checked on an actual transfer
  assign align_err = trn & (|(req.adr[1:0] & align_msk));

  //////////////////////////////////////////////////////////////////////
  // Counters and sticky flags
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      mon <= '0;
    end else begin
      // One count per completed transfer
      if (trn && req.wen) begin
        mon.cnt_wr <= mon.cnt_wr + tcb_cnt_t'(1);
      end
      if (trn && !req.wen) begin
        mon.cnt_rd <= mon.cnt_rd + tcb_cnt_t'(1);
      end
      // Flags stay set until reset
      if (hold_err) begin
        mon.err_hold <= 1'b1;
      end
      if (align_err) begin
        mon.err_align <= 1'b1;
      end
    end
  end

endmodule

//--- src/tcb_siz2ben.sv
`include "tcb_defines.svh"

module tcb_siz2ben (
  input  logic               tcb,
  input  logic               rst_n,
  input  logic               vld,
  input  tcb_pkg::tcb_req_t  req,
  output logic               rdy,
  output tcb_pkg::tcb_rsp_t  rsp,
  output logic               bvld,
  output tcb_pkg::tcb_breq_t breq,
  input  logic               brdy,
  input  tcb_pkg::tcb_dat_t  brdt
);

  import tcb_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Local signals
  //////////////////////////////////////////////////////////////////////

  // Byte offset aligned down to the transfer size
  logic [1:0] off;
  // Lanes of the transfer before the shift, and after it
  tcb_ben_t   ben_lo;
  tcb_ben_t   ben;
  // Write data copied onto every lane it may land on
  tcb_dat_t   wdt_rep;
  // Read transfer on this edge
  logic       rd_trn;

  // Offset and size of reads still in flight
  logic [1:0] off_pipe [`TCB_DLY];
  tcb_siz_t   siz_pipe [`TCB_DLY];
  // Response word with the addressed byte moved to lane 0
  tcb_dat_t   rdt_sh;

  //////////////////////////////////////////////////////////////////////
  // Request side
  //////////////////////////////////////////////////////////////////////

  // Handshake passes straight through
  assign bvld   = vld;
  assign rdy    = brdy;
  assign rd_trn = vld & brdy & ~req.wen;

  always_comb begin
    case (req.siz)
      2'd0: begin
        off     = req.adr[1:0];
        ben_lo  = 4'b0001;
        wdt_rep = {4{req.wdt[7:0]}};
      end
      2'd1: begin
        // Halfword drops address bit 0
        off     = {req.adr[1], 1'b0};
        ben_lo  = 4'b0011;
        wdt_rep = {2{req.wdt[15:0]}};
      end
      default: begin
        off     = 2'b00;
        ben_lo  = 4'b1111;
        wdt_rep = req.wdt;
      end
    endcase
  end

  assign ben = ben_lo << off;

  // Word address is the byte address without the lane bits
  assign breq = '{
    wen: req.wen,
    adr: req.adr[`TCB_ADR_W-1:2],
    ben: ben,
    wdt: wdt_rep
  };

  //////////////////////////////////////////////////////////////////////
  // Response side
  //////////////////////////////////////////////////////////////////////

  // Offset and size follow each read until its data returns
  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      for (int i = 0; i < `TCB_DLY; i++) begin
        off_pipe[i] <= '0;
        siz_pipe[i] <= '0;
      end
    end else if (rd_trn) begin
      off_pipe[0] <= off;
      siz_pipe[0] <= req.siz;
      for (int i = 1; i < `TCB_DLY; i++) begin
        off_pipe[i] <= off_pipe[i-1];
        siz_pipe[i] <= siz_pipe[i-1];
      end
    end
  end

  assign rdt_sh = brdt >> (8 * off_pipe[`TCB_DLY-1]);

  // Bytes above the transfer size read as zero
  always_comb begin
    case (siz_pipe[`TCB_DLY-1])
      2'd0:    rsp.rdt = {24'h000000, rdt_sh[7:0]};
      2'd1:    rsp.rdt = {16'h0000, rdt_sh[15:0]};
      default: rsp.rdt = rdt_sh;
    endcase
  end

endmodule

//--- src/tcb_mem.sv
`include "tcb_defines.svh"

module tcb_mem (
  input  logic               tcb,
  input  logic               rst_n,
  input  logic               bvld,
  input  tcb_pkg::tcb_breq_t breq,
  output logic               brdy,
  output tcb_pkg::tcb_dat_t  brdt
);

  import tcb_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Local signals
  //////////////////////////////////////////////////////////////////////

  // Word storage
  tcb_dat_t       mem [`TCB_MEM_DEPTH];
  tcb_mem_state_e state;

  // Old word fetched during the write stall
  tcb_dat_t old_q;
  tcb_dat_t merged;

  // Write seen on an idle memory
  logic wr_stall;
  logic rd_trn;
  logic wr_trn;

  //////////////////////////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////////////////////////

  assign wr_stall = (state == IDLE) && bvld && breq.wen;

  // Ready drops only while the old word is fetched
  assign brdy = ~wr_stall;

  assign rd_trn = bvld & brdy & ~breq.wen;
  // Can only happen in RMW
  assign wr_trn = bvld & brdy & breq.wen;

  // IDLE to RMW on a write, back after one cycle
  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (wr_stall) state <= RMW;
        RMW:     state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read-modify-write
  //////////////////////////////////////////////////////////////////////

  // Enabled lanes take new data, the rest keep the old word
  always_comb begin
    for (int i = 0; i < `TCB_BEN_W; i++) begin
      merged[8*i +: 8] = breq.ben[i] ? breq.wdt[8*i +: 8] : old_q[8*i +: 8];
    end
  end

  always_ff @(posedge tcb) begin
    if (wr_stall) begin
      old_q <= mem[breq.adr];
    end
    // If vld dropped in RMW nothing is written
    if (wr_trn) begin
      mem[breq.adr] <= merged;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read data
  //////////////////////////////////////////////////////////////////////

  // Registered one cycle after the read transfer, held otherwise
  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      brdt <= '0;
    end else if (rd_trn) begin
      brdt <= mem[breq.adr];
    end
  end

endmodule

//--- src/tcb_sys.sv
module tcb_sys (
  input  logic              tcb,
  input  logic              rst_n,
  input  logic              vld,
  input  tcb_pkg::tcb_req_t req,
  output logic              rdy,
  output tcb_pkg::tcb_rsp_t rsp,
  output tcb_pkg::tcb_mon_t mon
);

  import tcb_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Byte-enable bus between converter and memory
  //////////////////////////////////////////////////////////////////////

  logic      bvld;
  tcb_breq_t breq;
  logic      brdy;
  tcb_dat_t  brdt;

  // Monitor taps the manager side of the bus
  tcb_monitor u_monitor (
    .tcb   (tcb),
    .rst_n (rst_n),
    .vld   (vld),
    .req   (req),
    .rdy   (rdy),
    .mon   (mon)
  );

  // Log-size to byte-enable conversion
  tcb_siz2ben u_siz2ben (
    .tcb   (tcb),
    .rst_n (rst_n),
    .vld   (vld),
    .req   (req),
    .rdy   (rdy),
    .rsp   (rsp),
    .bvld  (bvld),
    .breq  (breq),
    .brdy  (brdy),
    .brdt  (brdt)
  );

  // Word SRAM
  tcb_mem u_mem (
    .tcb   (tcb),
    .rst_n (rst_n),
    .bvld  (bvld),
    .breq  (breq),
    .brdy  (brdy),
    .brdt  (brdt)
  );

endmodule

//--- dv/tcb_clk_gen.sv
module tcb_clk_gen (
  output logic tcb,
  output logic rst_n,
  input  logic rst_req
);

  timeunit 1ns;
  timeprecision 100ps;

  // 20 ns period
  initial begin
    tcb = 1'b0;
    forever #10 tcb = ~tcb;
  end

  // Power-on reset for 10 cycles, later resets follow rst_req one edge late
  initial begin
    rst_n <= 1'b0;
    repeat (10) @(posedge tcb);
    rst_n <= 1'b1;
    forever begin
      @(posedge tcb);
      rst_n <= ~rst_req;
    end
  end

endmodule

//--- dv/tcb_sva.sv
module tcb_sva (
  input logic              tcb,
  input logic              rst_n,
  input logic              vld,
  input tcb_pkg::tcb_req_t req,
  input logic              rdy
);

  timeunit 1ns;
  timeprecision 100ps;

  //////////////////////////////////////////////////////////////////////
  // Bus timing
  //////////////////////////////////////////////////////////////////////

  // Memory comes out of reset idle and ready
  rdy_after_reset: assert property (@(posedge tcb) !rst_n |=> rdy)
    else $error("rdy is low in the first cycle after reset");

  // Stalled request must not move
  req_stable: assert property (@(posedge tcb) disable iff (!rst_n)
    vld && !rdy |=> $stable(req))
    else $error("req changed while the transfer was stalled");

  // Only a fresh write on an idle memory stalls, and only for one cycle
  rdy_low_write: assert property (@(posedge tcb) disable iff (!rst_n)
    !rdy |-> vld && req.wen && $past(rdy))
    else $error("rdy low outside the write fetch cycle");

endmodule

bind tcb_sys tcb_sva u_sva (.*);

//--- dv/tcb_tb.sv
`include "tcb_defines.svh"

module tcb_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import tcb_pkg::*;

  localparam int unsigned RDY_TIMEOUT = 16;
  localparam int unsigned RST_TIMEOUT = 32;

  logic     tcb;
  logic     rst_n;
  logic     rst_req;
  logic     vld;
  tcb_req_t req;
  logic     rdy;
  tcb_rsp_t rsp;
  tcb_mon_t mon;

  // Byte-wide reference memory
  logic [7:0]  ref_mem [4*`TCB_MEM_DEPTH];
  // Pending read check for the next negedge
  logic        rd_due;
  tcb_dat_t    rd_exp;
  int unsigned n_rd;
  int unsigned n_wr;
  int unsigned n_err;
  int unsigned err_mark;
  int unsigned n_pass;
  int unsigned n_fail;
  event        abort_ev;

  tcb_clk_gen u_clk_gen (.tcb(tcb), .rst_n(rst_n), .rst_req(rst_req));

  tcb_sys u_tcb_sys (
    .tcb   (tcb),
    .rst_n (rst_n),
    .vld   (vld),
    .req   (req),
    .rdy   (rdy),
    .rsp   (rsp),
    .mon   (mon)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Bytes from the aligned-down offset land in the low lanes
  function automatic tcb_dat_t ref_read(input tcb_adr_t adr, input tcb_siz_t siz);
    int unsigned nbyte;
    int unsigned base;
    tcb_dat_t    dat;
    nbyte = 32'd1 << siz;
    base  = int'(adr) & ~(nbyte - 1);
    dat   = '0;
    for (int k = 0; k < int'(nbyte); k++) begin
      dat[8*k +: 8] = ref_mem[base + k];
    end
    return dat;
  endfunction

  function automatic void ref_write(input tcb_adr_t adr, input tcb_siz_t siz, input tcb_dat_t wdt);
    int unsigned nbyte;
    int unsigned base;
    nbyte = 32'd1 << siz;
    base  = int'(adr) & ~(nbyte - 1);
    for (int k = 0; k < int'(nbyte); k++) begin
      ref_mem[base + k] = wdt[8*k +: 8];
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_dat(input string name, input tcb_dat_t exp, input tcb_dat_t act);
    if (act !== exp) begin
      n_err++;
      $display("error: %0t ns %s exp=%h got=%h", $time, name, exp, act);
    end
  endtask

  task automatic check_cnt(input string name, input tcb_cnt_t exp, input tcb_cnt_t act);
    if (act !== exp) begin
      n_err++;
      $display("error: %0t ns %s exp=%0d got=%0d", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      n_err++;
      $display("error: %0t ns %s exp=%b got=%b", $time, name, exp, act);
    end
  endtask

  // Read data is due one edge after the read transfer
  always @(negedge tcb) begin
    if (rd_due) begin
      check_dat("rsp.rdt", rd_exp, rsp.rdt);
    end
    rd_due = 1'b0;
    // A transfer happens on the coming edge
    if (rst_n && vld && rdy) begin
      if (req.wen) begin
        ref_write(req.adr, req.siz, req.wdt);
      end else begin
        rd_exp = ref_read(req.adr, req.siz);
        rd_due = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // Present one request and hold it until rdy is seen
  task automatic issue(input logic wen, input tcb_adr_t adr, input tcb_siz_t siz,
                       input tcb_dat_t wdt);
    int unsigned cyc;
    tcb_req_t    r;
    r.wen = wen;
    r.adr = adr;
    r.siz = siz;
    r.wdt = wdt;
    @(posedge tcb);
    vld <= 1'b1;
    req <= r;
    cyc = 0;
    @(negedge tcb);
    while (!rdy && cyc < RDY_TIMEOUT) begin
      @(negedge tcb);
      cyc++;
    end
    if (!rdy) begin
      $display("timeout: rdy stayed low for %0d cycles at %0t ns", cyc, $time);
      -> abort_ev;
    end else if (wen) begin
      n_wr++;
    end else begin
      n_rd++;
    end
  endtask

  task automatic idle(input int unsigned n);
    @(posedge tcb);
    vld <= 1'b0;
    repeat (n) @(negedge tcb);
  endtask

  task automatic wait_reset_done();
    int unsigned cyc;
    cyc = 0;
    while (rst_n !== 1'b1 && cyc < RST_TIMEOUT) begin
      @(negedge tcb);
      cyc++;
    end
    if (rst_n !== 1'b1) begin
      $display("timeout: reset was not released after %0d cycles", cyc);
      -> abort_ev;
    end
  endtask

  task automatic check_counts();
    check_cnt("mon.cnt_rd", tcb_cnt_t'(n_rd), mon.cnt_rd);
    check_cnt("mon.cnt_wr", tcb_cnt_t'(n_wr), mon.cnt_wr);
  endtask

  task automatic report_test(input string name);
    if (n_err == err_mark) begin
      n_pass++;
      $display("test %s: pass", name);
    end else begin
      n_fail++;
      $display("test %s: FAIL with %0d errors", name, n_err - err_mark);
    end
    err_mark = n_err;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned a;
    tcb_siz_t    s;
    logic        w;
    void'($urandom(64748));
    vld     <= 1'b0;
    req     <= '0;
    rst_req <= 1'b0;
    wait_reset_done();

    issue(1'b1, 10'h100, 2'd2, 32'hdeadbeef);
    issue(1'b0, 10'h100, 2'd2, '0);
    idle(2);
    check_dat("rsp.rdt", 32'hdeadbeef, rsp.rdt);
    check_counts();
    report_test("word_write_read");

    // Byte into lane 0, halfword into lanes 3:2, lane 1 untouched
    issue(1'b1, 10'h104, 2'd2, 32'h11223344);
    issue(1'b1, 10'h104, 2'd0, 32'h000000aa);
    issue(1'b1, 10'h106, 2'd1, 32'h0000bbcc);
    issue(1'b0, 10'h104, 2'd2, '0);
    idle(2);
    check_dat("rsp.rdt", 32'hbbcc33aa, rsp.rdt);
    report_test("subword_merge");

    for (int off = 0; off < 4; off++) begin
      issue(1'b0, tcb_adr_t'(32'h100 + off), 2'd0, '0);
    end
    for (int off = 0; off < 4; off += 2) begin
      issue(1'b0, tcb_adr_t'(32'h100 + off), 2'd1, '0);
    end
    issue(1'b0, 10'h100, 2'd2, '0);
    idle(2);
    report_test("subword_reads");

    // Known contents in bytes 0 to 63 first
    for (int i = 0; i < 16; i++) begin
      issue(1'b1, tcb_adr_t'(4 * i), 2'd2, $urandom);
    end
    // Mostly reads so that reads run back to back
    for (int i = 0; i < 200; i++) begin
      w = ($urandom_range(0, 2) == 0);
      s = tcb_siz_t'($urandom_range(0, 2));
      a = $urandom_range(0, 63) & ~((32'd1 << s) - 1);
      issue(w, tcb_adr_t'(a), s, $urandom);
      if ($urandom_range(0, 7) == 0) begin
        idle(1);
      end
    end
    idle(2);
    check_counts();
    check_flag("mon.err_hold", 1'b0, mon.err_hold);
    check_flag("mon.err_align", 1'b0, mon.err_align);
    report_test("random_traffic");

    // Odd halfword address reads the aligned-down pair
    issue(1'b0, 10'h101, 2'd1, '0);
    idle(2);
    check_dat("rsp.rdt", 32'h0000beef, rsp.rdt);
    check_flag("mon.err_align", 1'b1, mon.err_align);
    check_flag("mon.err_hold", 1'b0, mon.err_hold);
    report_test("misaligned_read");

    // Write stalls, vld drops for one cycle, then the write is retried
    @(posedge tcb);
    vld     <= 1'b1;
    req.wen <= 1'b1;
    req.adr <= 10'h200;
    req.siz <= 2'd2;
    req.wdt <= 32'h5a5a0f0f;
    @(negedge tcb);
    check_flag("rdy", 1'b0, rdy);
    @(posedge tcb);
    vld <= 1'b0;
    issue(1'b1, 10'h200, 2'd2, 32'h5a5a0f0f);
    issue(1'b0, 10'h200, 2'd2, '0);
    idle(2);
    check_flag("mon.err_hold", 1'b1, mon.err_hold);
    check_counts();
    @(posedge tcb);
    rst_req <= 1'b1;
    repeat (3) @(posedge tcb);
    rst_req <= 1'b0;
    wait_reset_done();
    @(negedge tcb);
    n_rd = 0;
    n_wr = 0;
    check_counts();
    check_flag("mon.err_hold", 1'b0, mon.err_hold);
    check_flag("mon.err_align", 1'b0, mon.err_align);
    report_test("hold_error_and_reset");

    $display("summary: %0d tests passed, %0d tests failed, %0d errors", n_pass, n_fail, n_err);
    if (n_err == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Any wait that runs out ends the run here
  initial begin
    @(abort_ev);
    $display("summary: run aborted after %0d tests, %0d errors", n_pass + n_fail, n_err);
    $display("Test failures found");
    $finish;
  end

endmodule

//--- tcb_sys.f
+incdir+include
src/tcb_pkg.sv
src/tcb_monitor.sv
src/tcb_siz2ben.sv
src/tcb_mem.sv
src/tcb_sys.sv
dv/tcb_clk_gen.sv
dv/tcb_sva.sv
dv/tcb_tb.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run, and decide on the pass line in sim.log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f tcb_sys.f --top-module tcb_tb -o tcb_sim > build.log 2>&1 ||
  { cat build.log; exit 1; }
./obj_dir/tcb_sim +verilator+error+limit+100 > sim.log 2>&1
grep -qx 'All tests passed!' sim.log && echo "PASS" || { cat sim.log; echo "FAIL"; exit 1; }
